// ==== bench/mem_stage_chk.sv ====
`timescale 1ns/1ns

module mem_stage_chk
    import stage_bus_pkg::*;
(
    input logic              clk,
    input logic              reset,
    input logic              out_allowin,
    input logic              out_valid,
    input logic              dcache_req,
    input logic              dcache_addr_ok,
    input logic [1:0]        dcache_size,
    input logic [LANES-1:0]  dcache_wstrb,
    input logic [DATA_W-1:0] dcache_addr,
    input logic [DATA_W-1:0] dcache_wdata
);

    int fail_count = 0;

    // Requests only go out when the next stage can take the result
    req_needs_allowin: assert property (
        @(posedge clk) disable iff (reset) dcache_req |-> out_allowin
    ) else begin
        $error("dcache_req high while out_allowin is low");
        fail_count++;
    end

    // Stage holds its instruction until the cache takes the address
    req_held: assert property (
        @(posedge clk) disable iff (reset)
        dcache_req && !dcache_addr_ok |=> $stable(dcache_addr) && $stable(dcache_wdata)
            && $stable(dcache_wstrb) && $stable(dcache_size)
    ) else begin
        $error("pending cache request changed before addr_ok");
        fail_count++;
    end

    valid_low_in_reset: assert property (
        @(posedge clk) reset |=> !out_valid
    ) else begin
        $error("out_valid high after a reset cycle");
        fail_count++;
    end

endmodule

bind mem_stage_top mem_stage_chk chk_i (.*);

// ==== bench/mem_stage_tb.sv ====
`timescale 1ns/1ns

module mem_stage_tb
    import mem_op_pkg::*, stage_bus_pkg::*;
();

    localparam int          N_ROWS  = 25;
    localparam int          TIMEOUT = N_ROWS * 10 + 50;
    localparam logic [31:0] RT      = 32'h1122_3344;
    localparam int          OP_W    = LOAD_OP_W + STORE_OP_W;

    // Op field is {load one-hot, store one-hot}
    localparam logic [OP_W-1:0]
        OP_NOP = '0,
        OP_LB  = 1 << (STORE_OP_W + LD_LB),
        OP_LBU = 1 << (STORE_OP_W + LD_LBU),
        OP_LH  = 1 << (STORE_OP_W + LD_LH),
        OP_LHU = 1 << (STORE_OP_W + LD_LHU),
        OP_LW  = 1 << (STORE_OP_W + LD_LW),
        OP_LWL = 1 << (STORE_OP_W + LD_LWL),
        OP_LWR = 1 << (STORE_OP_W + LD_LWR),
        OP_SB  = 1 << ST_SB,
        OP_SH  = 1 << ST_SH,
        OP_SW  = 1 << ST_SW,
        OP_SWL = 1 << ST_SWL,
        OP_SWR = 1 << ST_SWR;

    typedef struct packed {
        logic [OP_W-1:0]   op;
        logic [DATA_W-1:0] base;
        logic [15:0]       ofs;
        logic [DATA_W-1:0] vaddr;
        size_t             size;
        logic [DATA_W-1:0] paddr;
        logic [LANES-1:0]  wstrb;
        logic [DATA_W-1:0] wdata;
        exccode_t          code;
    } row_t;

    // op, base, offset, virtual address, size, cache address, wstrb, wdata, exception code
    localparam row_t STIM [N_ROWS] = '{
        '{OP_SB,  'h1000, 'h0, 'h1000, SIZE_BYTE, 'h1000, 'b0001, 'h00000044, EX_NONE},
        '{OP_SB,  'h1000, 'h1, 'h1001, SIZE_BYTE, 'h1001, 'b0010, 'h00004400, EX_NONE},
        '{OP_SB,  'h1000, 'h2, 'h1002, SIZE_BYTE, 'h1002, 'b0100, 'h00440000, EX_NONE},
        '{OP_SB,  'h1000, 'h3, 'h1003, SIZE_BYTE, 'h1003, 'b1000, 'h44000000, EX_NONE},
        '{OP_SH,  'h1000, 'h0, 'h1000, SIZE_HALF, 'h1000, 'b0011, 'h00003344, EX_NONE},
        '{OP_SH,  'h1000, 'h2, 'h1002, SIZE_HALF, 'h1002, 'b1100, 'h33440000, EX_NONE},
        '{OP_SW,  'h1000, 'h0, 'h1000, SIZE_WORD, 'h1000, 'b1111, 'h11223344, EX_NONE},
        '{OP_SWL, 'h1000, 'h0, 'h1000, SIZE_BYTE, 'h1000, 'b0001, 'h00000011, EX_NONE},
        '{OP_SWL, 'h1000, 'h1, 'h1001, SIZE_HALF, 'h1000, 'b0011, 'h00001122, EX_NONE},
        '{OP_SWL, 'h1000, 'h2, 'h1002, SIZE_WORD, 'h1000, 'b0111, 'h00112233, EX_NONE},
        '{OP_SWL, 'h1000, 'h3, 'h1003, SIZE_WORD, 'h1000, 'b1111, 'h11223344, EX_NONE},
        '{OP_SWR, 'h1000, 'h0, 'h1000, SIZE_WORD, 'h1000, 'b1111, 'h11223344, EX_NONE},
        '{OP_SWR, 'h1000, 'h1, 'h1001, SIZE_WORD, 'h1001, 'b1110, 'h22334400, EX_NONE},
        '{OP_SWR, 'h1000, 'h2, 'h1002, SIZE_HALF, 'h1002, 'b1100, 'h33440000, EX_NONE},
        '{OP_SWR, 'h1000, 'h3, 'h1003, SIZE_BYTE, 'h1003, 'b1000, 'h44000000, EX_NONE},
        '{OP_LB,  'h80001000, 'h3, 'h80001003, SIZE_BYTE, 'h00001003, 'b0, 'h0, EX_NONE},
        '{OP_LHU, 'ha0002000, 'hfffe, 'ha0001ffe, SIZE_HALF, 'h00001ffe, 'b0, 'h0, EX_NONE},
        '{OP_LW,  'hc0000100, 'h4, 'hc0000104, SIZE_WORD, 'h00000104, 'b0, 'h0, EX_NONE},
        '{OP_LW,  'h1000, 'h2, 'h1002, SIZE_BYTE, 'h0, 'b0, 'h0, EX_ADEL},
        '{OP_LWL, 'he0000010, 'h1, 'he0000011, SIZE_HALF, 'h00000010, 'b0, 'h0, EX_NONE},
        '{OP_NOP, 'h1000, 'h8, 'h1008, SIZE_BYTE, 'h0, 'b0, 'h0, EX_NONE},
        '{OP_LH,  'h1000, 'h1, 'h1001, SIZE_BYTE, 'h0, 'b0, 'h0, EX_ADEL},
        '{OP_LWR, 'h00400000, 'h2, 'h00400002, SIZE_HALF, 'h00400002, 'b0, 'h0, EX_NONE},
        '{OP_SW,  'h80000000, 'h1, 'h80000001, SIZE_BYTE, 'h0, 'b0, 'h0, EX_ADES},
        '{OP_LBU, 'hfffffff0, 'hf, 'hffffffff, SIZE_BYTE, 'h1fffffff, 'b0, 'h0, EX_NONE}
    };

    logic clk, reset, in_valid, in_allowin, out_allowin, out_valid;
    logic out_is_load, out_ex, dcache_req, dcache_wr, dcache_addr_ok;
    logic [LOAD_OP_W-1:0]  in_load_op, out_load_op;
    logic [STORE_OP_W-1:0] in_store_op;
    logic [DATA_W-1:0]     in_base, in_rt_value, in_pc, out_addr, out_pc, out_badvaddr;
    logic [DATA_W-1:0]     dcache_addr, dcache_wdata;
    logic [15:0]           in_offset;
    logic [REG_ADDR_W-1:0] in_dest, out_dest;
    logic [4:0]            out_exccode;
    logic [1:0]            dcache_size;
    logic [LANES-1:0]      dcache_wstrb;

    logic [31:0] rng = 32'he08b1470;
    int          ok_delay = 0;
    int          drive_idx = 0;
    int          done_count = 0;
    int          value_errs = 0;
    int          proto_errs = 0;
    int          assert_errs = 0;
    int          cycles = 0;
    bit          req_seen = 1'b0;
    int          in_stage [$];

    mem_stage_top mem_stage_top_i (.*);

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] pc_of(input int k);
        return 32'hbfc0_0000 + 32'(k) * 4;
    endfunction

    task automatic report_mismatch(input string what, input int k,
                                   input logic [31:0] got, input logic [31:0] exp);
        value_errs++;
        $display("Fail %0t: row %0d %s is %h, expected %h", $time, k, what, got, exp);
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        row_t r;
        reset          = 1'b1;
        in_valid       = 1'b0;
        in_load_op     = '0;
        in_store_op    = '0;
        in_base        = '0;
        in_offset      = '0;
        in_rt_value    = '0;
        in_dest        = '0;
        in_pc          = '0;
        out_allowin    = 1'b1;
        dcache_addr_ok = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        if (out_valid !== 1'b0 || dcache_req !== 1'b0 || in_allowin !== 1'b1) begin
            $display("Error at %0t: handshake outputs not idle after reset", $time);
            proto_errs++;
        end
        for (int i = 0; i < N_ROWS; i++) begin
            r         = STIM[i];
            drive_idx = i;
            in_valid  = 1'b1;
            {in_load_op, in_store_op} = r.op;
            in_base     = r.base;
            in_offset   = r.ofs;
            in_rt_value = RT;
            in_dest     = REG_ADDR_W'(i + 1);
            in_pc       = pc_of(i);
            @(posedge clk);
            while (!in_allowin) begin
                @(posedge clk);
            end
            #1;
        end
        in_valid = 1'b0;
        wait (done_count == N_ROWS);
        @(posedge clk);
        assert_errs = mem_stage_top_i.chk_i.fail_count;
        $display("Errors: %0d value, %0d protocol, %0d assertion",
                 value_errs, proto_errs, assert_errs);
        if (value_errs + proto_errs + assert_errs == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // Cache takes the address after 0 to 3 cycles and the next stage stalls one cycle in four
    initial begin
        logic accepted;
        forever begin
            @(posedge clk);
            accepted = dcache_req && dcache_addr_ok;
            #1;
            rng = xorshift32(rng);
            if (accepted) begin
                ok_delay = int'(rng[1:0]);
            end else if (ok_delay > 0) begin
                ok_delay--;
            end
            rng = xorshift32(rng);
            dcache_addr_ok = (ok_delay == 0);
            out_allowin    = (rng[1:0] != 2'b00);
        end
    end

    always @(posedge clk) begin
        row_t                 r;
        int                   k;
        logic                 need;
        logic                 is_ex;
        logic                 is_st;
        logic [LOAD_OP_W-1:0] ld_op;
        logic [31:0]          vaddr;
        if (!reset && in_stage.size() > 0) begin
            k     = in_stage[0];
            r     = STIM[k];
            is_ex = (r.code != EX_NONE);
            is_st = |r.op[STORE_OP_W-1:0];
            ld_op = r.op[OP_W-1:STORE_OP_W];
            vaddr = r.vaddr;
            need  = (r.op != '0) && !is_ex;
            if (dcache_req && !need) begin
                $display("Error at %0t: row %0d made a cache request it must not make",
                         $time, k);
                proto_errs++;
            end
            if (dcache_req && dcache_addr_ok) begin
                req_seen = 1'b1;
                if (dcache_wr !== is_st)
                    report_mismatch("dcache_wr", k, dcache_wr, is_st);
                if (dcache_size !== r.size)
                    report_mismatch("dcache_size", k, dcache_size, r.size);
                if (dcache_addr !== r.paddr)
                    report_mismatch("dcache_addr", k, dcache_addr, r.paddr);
                if (dcache_wstrb !== r.wstrb)
                    report_mismatch("dcache_wstrb", k, dcache_wstrb, r.wstrb);
                if (dcache_wdata !== r.wdata)
                    report_mismatch("dcache_wdata", k, dcache_wdata, r.wdata);
            end
            if (out_valid && out_allowin) begin
                if (need && !req_seen) begin
                    $display("Error at %0t: row %0d left without a cache request", $time, k);
                    proto_errs++;
                end
                if (out_pc !== pc_of(k))
                    report_mismatch("out_pc", k, out_pc, pc_of(k));
                if (out_dest !== REG_ADDR_W'(k + 1))
                    report_mismatch("out_dest", k, out_dest, k + 1);
                if (out_addr !== vaddr)
                    report_mismatch("out_addr", k, out_addr, vaddr);
                if (out_ex !== is_ex)
                    report_mismatch("out_ex", k, out_ex, is_ex);
                if (out_exccode !== r.code)
                    report_mismatch("out_exccode", k, out_exccode, r.code);
                if (out_is_load !== (ld_op != 0))
                    report_mismatch("out_is_load", k, out_is_load, ld_op != 0);
                if (out_load_op !== ld_op)
                    report_mismatch("out_load_op", k, out_load_op, ld_op);
                if (is_ex && out_badvaddr !== vaddr)
                    report_mismatch("out_badvaddr", k, out_badvaddr, vaddr);
                req_seen = 1'b0;
                done_count++;
                void'(in_stage.pop_front());
            end
        end else if (!reset && out_valid === 1'b1) begin
            $display("Error at %0t: out_valid high with no instruction in the stage", $time);
            proto_errs++;
        end
        if (!reset && in_valid && in_allowin) begin
            in_stage.push_back(drive_idx);
        end
    end

    initial begin
        while (cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles with %0d of %0d rows done",
                 cycles, done_count, N_ROWS);
        $display("** FAIL **");
        $finish;
    end

endmodule

// ==== design/mem_addr_unit.sv ====
`timescale 1ns/1ns

module mem_addr_unit
    import mem_op_pkg::*, stage_bus_pkg::*;
(
    input  logic                stage_valid,
    input  mem_in_t             stage_bus,
    output logic [DATA_W-1:0]   addr,
    output logic [DATA_W-1:0]   phys_addr,
    output size_t               size,
    output logic                ex,
    output exccode_t            exccode,
    output logic                is_mem,
    output logic                is_store,
    store_lane_if.feed          lanes [LANES]
);

    logic [LOAD_OP_W-1:0]  ld;
    logic [STORE_OP_W-1:0] st;
    logic [1:0]            ofs;
    logic                  adel;
    logic                  ades;
    logic                  size_word;
    logic                  size_half;
    logic                  left_op;
    logic                  right_op;
    logic [DATA_W-1:0]     aligned_addr;

    assign ld = stage_bus.load_op;
    assign st = stage_bus.store_op;

    // Base plus sign-extended offset
    assign addr = stage_bus.base + {{(DATA_W-16){stage_bus.offset[15]}}, stage_bus.offset};
    assign ofs  = addr[1:0];

    assign is_store = |st;
    assign is_mem   = (|ld) | is_store;

    assign adel = (ld[LD_LW] & (ofs != 2'b00))
                | ((ld[LD_LH] | ld[LD_LHU]) & ofs[0]);
    assign ades = (st[ST_SW] & (ofs != 2'b00))
                | (st[ST_SH] & ofs[0]);

    assign ex      = adel | ades;
    assign exccode = adel ? EX_ADEL :
                     ades ? EX_ADES :
                            EX_NONE;

    assign left_op  = ld[LD_LWL] | st[ST_SWL];
    assign right_op = ld[LD_LWR] | st[ST_SWR];

    // Unaligned left/right accesses shrink toward the word edge
    assign size_word = ld[LD_LW] | st[ST_SW]
                     | (left_op & ofs[1])
                     | (right_op & ~ofs[1]);
    assign size_half = ld[LD_LH] | ld[LD_LHU] | st[ST_SH]
                     | (left_op & (ofs == 2'b01))
                     | (right_op & (ofs == 2'b10));

    assign size = size_word ? SIZE_WORD :
                  size_half ? SIZE_HALF :
                              SIZE_BYTE;

    // LWL/SWL address the whole word
    assign aligned_addr = left_op ? {addr[DATA_W-1:2], 2'b00} : addr;
    assign phys_addr    = aligned_addr & PHYS_MASK;

    for (genvar i = 0; i < LANES; i++) begin : g_feed
        assign lanes[i].store_op    = (stage_valid && !ex) ? st : '0;
        assign lanes[i].byte_offset = ofs;
        assign lanes[i].rt_value    = stage_bus.rt_value;
    end

endmodule

// ==== design/mem_op_pkg.sv ====
package mem_op_pkg;

    // Load one-hot, bit order LB LBU LH LHU LW LWL LWR
    localparam int LOAD_OP_W = 7;
    // Store one-hot, bit order SB SH SW SWL SWR
    localparam int STORE_OP_W = 5;

    localparam int LD_LB  = 0;
    localparam int LD_LBU = 1;
    localparam int LD_LH  = 2;
    localparam int LD_LHU = 3;
    localparam int LD_LW  = 4;
    localparam int LD_LWL = 5;
    localparam int LD_LWR = 6;

    localparam int ST_SB  = 0;
    localparam int ST_SH  = 1;
    localparam int ST_SW  = 2;
    localparam int ST_SWL = 3;
    localparam int ST_SWR = 4;

    // Cache access size
    typedef logic [1:0] size_t;

    localparam size_t SIZE_BYTE = 2'd0;
    localparam size_t SIZE_HALF = 2'd1;
    localparam size_t SIZE_WORD = 2'd2;

    // CP0 exception codes used by this stage
    typedef logic [4:0] exccode_t;

    localparam exccode_t EX_NONE = 5'd0;
    localparam exccode_t EX_ADEL = 5'd4;
    localparam exccode_t EX_ADES = 5'd5;

    // Fixed segment translation, top three bits cleared
    localparam logic [31:0] PHYS_MASK = 32'h1fff_ffff;

endpackage

// ==== design/mem_req_port.sv ====
`timescale 1ns/1ns

module mem_req_port
    import mem_op_pkg::*, stage_bus_pkg::*;
(
    input  logic                stage_valid,
    input  logic                out_allowin,
    input  logic                is_mem,
    input  logic                is_store,
    input  logic                ex,
    input  logic [DATA_W-1:0]   phys_addr,
    input  size_t               size,
    store_lane_if.drain         lanes [LANES],
    output logic                dcache_req,
    output logic                dcache_wr,
    output logic [1:0]          dcache_size,
    output logic [LANES-1:0]    dcache_wstrb,
    output logic [DATA_W-1:0]   dcache_addr,
    output logic [DATA_W-1:0]   dcache_wdata,
    input  logic                dcache_addr_ok,
    output logic                req_done
);

    logic need_req;

    for (genvar i = 0; i < LANES; i++) begin : g_drain
        assign dcache_wdata[8*i +: 8] = lanes[i].byte_data;
        assign dcache_wstrb[i]        = lanes[i].byte_strb;
    end

    // Faulting accesses never reach the cache
    assign need_req = is_mem && !ex;

    // Held back while the next stage cannot take the result
    assign dcache_req  = stage_valid && out_allowin && need_req;
    assign dcache_wr   = is_store;
    assign dcache_size = size;
    assign dcache_addr = phys_addr;

    assign req_done = !need_req || (dcache_req && dcache_addr_ok);

endmodule

// ==== design/mem_stage_pipe.sv ====
`timescale 1ns/1ns

module mem_stage_pipe
    import mem_op_pkg::*, stage_bus_pkg::*;
(
    input  logic                clk,
    input  logic                reset,
    input  logic                in_valid,
    output logic                in_allowin,
    input  mem_in_t             in_bus,
    input  logic                out_allowin,
    input  logic                req_done,
    input  logic [DATA_W-1:0]   addr,
    input  logic                ex,
    input  exccode_t            exccode,
    output logic                stage_valid,
    output mem_in_t             stage_bus,
    output logic                out_valid,
    output mem_out_t            out_bus
);

    logic    valid_r;
    mem_in_t bus_r;
    logic    ready_go;

    assign ready_go   = req_done;
    assign in_allowin = !valid_r || (ready_go && out_allowin);
    assign out_valid  = valid_r && ready_go;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_r <= 1'b0;
        end else if (in_allowin) begin
            valid_r <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_allowin) begin
            bus_r <= in_bus;
        end
    end

    assign stage_valid = valid_r;
    assign stage_bus   = bus_r;

    always_comb begin
        out_bus          = '0;
        out_bus.is_load  = |bus_r.load_op;
        out_bus.load_op  = bus_r.load_op;
        out_bus.addr     = addr;
        out_bus.dest     = bus_r.dest;
        out_bus.pc       = bus_r.pc;
        out_bus.ex       = ex;
        out_bus.exccode  = exccode;
        // bad address only reported with the fault
        out_bus.badvaddr = ex ? addr : '0;
    end

endmodule

// ==== design/mem_stage_top.sv ====
`timescale 1ns/1ns

module mem_stage_top
    import mem_op_pkg::*, stage_bus_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    in_valid,
    output logic                    in_allowin,
    input  logic [LOAD_OP_W-1:0]    in_load_op,
    input  logic [STORE_OP_W-1:0]   in_store_op,
    input  logic [DATA_W-1:0]       in_base,
    input  logic [15:0]             in_offset,
    input  logic [DATA_W-1:0]       in_rt_value,
    input  logic [REG_ADDR_W-1:0]   in_dest,
    input  logic [DATA_W-1:0]       in_pc,
    input  logic                    out_allowin,
    output logic                    out_valid,
    output logic                    out_is_load,
    output logic [LOAD_OP_W-1:0]    out_load_op,
    output logic [DATA_W-1:0]       out_addr,
    output logic [REG_ADDR_W-1:0]   out_dest,
    output logic [DATA_W-1:0]       out_pc,
    output logic                    out_ex,
    output logic [4:0]              out_exccode,
    output logic [DATA_W-1:0]       out_badvaddr,
    output logic                    dcache_req,
    output logic                    dcache_wr,
    output logic [1:0]              dcache_size,
    output logic [LANES-1:0]        dcache_wstrb,
    output logic [DATA_W-1:0]       dcache_addr,
    output logic [DATA_W-1:0]       dcache_wdata,
    input  logic                    dcache_addr_ok
);

    mem_in_t           in_bus;
    mem_in_t           stage_bus;
    mem_out_t          out_bus;
    logic              stage_valid;
    logic              req_done;
    logic [DATA_W-1:0] addr;
    logic [DATA_W-1:0] phys_addr;
    size_t             size;
    logic              ex;
    exccode_t          exccode;
    logic              is_mem;
    logic              is_store;

    store_lane_if lane_bus [LANES] ();

    assign in_bus = '{
        load_op:  in_load_op,
        store_op: in_store_op,
        base:     in_base,
        offset:   in_offset,
        rt_value: in_rt_value,
        dest:     in_dest,
        pc:       in_pc
    };

    mem_stage_pipe u_pipe (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (in_valid),
        .in_allowin  (in_allowin),
        .in_bus      (in_bus),
        .out_allowin (out_allowin),
        .req_done    (req_done),
        .addr        (addr),
        .ex          (ex),
        .exccode     (exccode),
        .stage_valid (stage_valid),
        .stage_bus   (stage_bus),
        .out_valid   (out_valid),
        .out_bus     (out_bus)
    );

    mem_addr_unit u_addr (
        .stage_valid (stage_valid),
        .stage_bus   (stage_bus),
        .addr        (addr),
        .phys_addr   (phys_addr),
        .size        (size),
        .ex          (ex),
        .exccode     (exccode),
        .is_mem      (is_mem),
        .is_store    (is_store),
        .lanes       (lane_bus)
    );

    for (genvar i = 0; i < LANES; i++) begin : g_lane
        store_byte_lane #(
            .LANE (i)
        ) u_lane (
            .lane (lane_bus[i])
        );
    end

    mem_req_port u_req (
        .stage_valid    (stage_valid),
        .out_allowin    (out_allowin),
        .is_mem         (is_mem),
        .is_store       (is_store),
        .ex             (ex),
        .phys_addr      (phys_addr),
        .size           (size),
        .lanes          (lane_bus),
        .dcache_req     (dcache_req),
        .dcache_wr      (dcache_wr),
        .dcache_size    (dcache_size),
        .dcache_wstrb   (dcache_wstrb),
        .dcache_addr    (dcache_addr),
        .dcache_wdata   (dcache_wdata),
        .dcache_addr_ok (dcache_addr_ok),
        .req_done       (req_done)
    );

    assign out_is_load  = out_bus.is_load;
    assign out_load_op  = out_bus.load_op;
    assign out_addr     = out_bus.addr;
    assign out_dest     = out_bus.dest;
    assign out_pc       = out_bus.pc;
    assign out_ex       = out_bus.ex;
    assign out_exccode  = out_bus.exccode;
    assign out_badvaddr = out_bus.badvaddr;

endmodule

// ==== design/stage_bus_pkg.sv ====
package stage_bus_pkg;

    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int LANES      = 4;

    // Instruction as held in the stage register
    typedef struct packed {
        logic [mem_op_pkg::LOAD_OP_W-1:0]  load_op;
        logic [mem_op_pkg::STORE_OP_W-1:0] store_op;
        logic [DATA_W-1:0]                 base;
        logic [15:0]                       offset;
        logic [DATA_W-1:0]                 rt_value;
        logic [REG_ADDR_W-1:0]             dest;
        logic [DATA_W-1:0]                 pc;
    } mem_in_t;

    // Result bus towards the next stage
    typedef struct packed {
        logic                              is_load;
        logic [mem_op_pkg::LOAD_OP_W-1:0]  load_op;
        logic [DATA_W-1:0]                 addr;
        logic [REG_ADDR_W-1:0]             dest;
        logic [DATA_W-1:0]                 pc;
        logic                              ex;
        mem_op_pkg::exccode_t              exccode;
        logic [DATA_W-1:0]                 badvaddr;
    } mem_out_t;

endpackage

// ==== design/store_byte_lane.sv ====
`timescale 1ns/1ns

module store_byte_lane
    import mem_op_pkg::*;
#(
    parameter int LANE = 0
)
(
    store_lane_if.lane lane
);

    localparam logic [1:0] LANE_IDX = LANE[1:0];

    logic [1:0] src;
    logic       strb;

    // src is the rt byte that lands in this lane
    always_comb begin
        src  = 2'd0;
        strb = 1'b0;
        if (lane.store_op[ST_SB]) begin
            src  = 2'd0;
            strb = (LANE_IDX == lane.byte_offset);
        end else if (lane.store_op[ST_SH]) begin
            src  = {1'b0, LANE_IDX[0]};
            strb = (LANE_IDX[1] == lane.byte_offset[1]);
        end else if (lane.store_op[ST_SW]) begin
            src  = LANE_IDX;
            strb = 1'b1;
        end else if (lane.store_op[ST_SWL]) begin
            // rt shifted right by 3 - offset bytes
            src  = LANE_IDX + 2'd3 - lane.byte_offset;
            strb = (LANE_IDX <= lane.byte_offset);
        end else if (lane.store_op[ST_SWR]) begin
            // rt shifted left by offset bytes
            src  = LANE_IDX - lane.byte_offset;
            strb = (LANE_IDX >= lane.byte_offset);
        end
    end

    assign lane.byte_strb = strb;
    assign lane.byte_data = strb ? lane.rt_value[8*src +: 8] : 8'h00;

endmodule

// ==== design/store_lane_if.sv ====
`timescale 1ns/1ns

interface store_lane_if
    import mem_op_pkg::*, stage_bus_pkg::*;
();

    logic [STORE_OP_W-1:0] store_op;
    logic [1:0]            byte_offset;
    logic [DATA_W-1:0]     rt_value;
    logic [7:0]            byte_data;
    logic                  byte_strb;

    modport feed (
        output store_op,
        output byte_offset,
        output rt_value
    );

    modport lane (
        input  store_op,
        input  byte_offset,
        input  rt_value,
        output byte_data,
        output byte_strb
    );

    modport drain (
        input byte_data,
        input byte_strb
    );

endinterface

// ==== project.f ====
design/mem_op_pkg.sv
design/stage_bus_pkg.sv
design/store_lane_if.sv
design/mem_addr_unit.sv
design/store_byte_lane.sv
design/mem_req_port.sv
design/mem_stage_pipe.sv
design/mem_stage_top.sv
bench/mem_stage_chk.sv
bench/mem_stage_tb.sv
